/* compile.f */
rtl/mem_pkg.sv
rtl/bus_pkg.sv
rtl/dmem_bank.sv
rtl/load_align.sv
rtl/mem_stage.sv
rtl/io_regs.sv
rtl/mem_subsys_top.sv
test/mem_checker.sv
test/tb_mem_subsys.sv

/* Makefile */
SIM      = verilator
TOP      = tb_mem_subsys
FILELIST = compile.f
FLAGS    = --binary --timing --timescale 1ns/100ps --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log

sim:
	$(SIM) $(FLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: sim clean

/* test/tb_mem_subsys.sv */
`timescale 1ns/100ps

module tb_mem_subsys;

    localparam int             DEPTH_WORDS  = 16384;
    localparam int             IO_WAIT      = 2;
    localparam int             RESET_CYCLES = 16;
    localparam int             N_REGION     = 64;  // Words in the random RAM window
    localparam int             N_DIRECTED   = 80;  // Bound on the directed accesses
    localparam int             N_RANDOM     = 400;
    localparam int             MAX_CYCLES   = (N_REGION + N_DIRECTED + N_RANDOM) * (IO_WAIT + 6)
                                              + 200;
    localparam logic [31:0]    RAND_SEED    = 32'he1b6_dee9;
    localparam mem_pkg::addr_t REGION_BASE  = 32'h0000_2000;
    localparam mem_pkg::addr_t EXT_ADDR     = 32'h0000_0200;
    localparam mem_pkg::addr_t IO_BASE      = {bus_pkg::io_base_c, 12'h000};

    logic               clk;
    logic               rst_i;
    logic               mem_read;
    logic               mem_write;
    mem_pkg::mem_type_t mem_type;
    mem_pkg::addr_t     addr;
    mem_pkg::word_t     wdata;
    logic               stall;
    logic               load_valid;
    mem_pkg::word_t     load_data;
    mem_pkg::word_t     gpio;
    int                 loads_checked;
    int                 data_errors;
    int                 proto_errors;
    int                 cycles;

    mem_subsys_top #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .IO_WAIT     (IO_WAIT)
    ) mem_subsys_top_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .mem_read_i   (mem_read),
        .mem_write_i  (mem_write),
        .mem_type_i   (mem_type),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .stall_o      (stall),
        .load_valid_o (load_valid),
        .load_data_o  (load_data),
        .gpio_o       (gpio)
    );

    mem_checker mem_checker_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .mem_read_i      (mem_read),
        .mem_write_i     (mem_write),
        .mem_type_i      (mem_type),
        .addr_i          (addr),
        .wdata_i         (wdata),
        .stall_i         (stall),
        .load_valid_i    (load_valid),
        .load_data_i     (load_data),
        .gpio_i          (gpio),
        .loads_checked_o (loads_checked),
        .data_errors_o   (data_errors),
        .proto_errors_o  (proto_errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Present one access and hold it until it is taken
    task automatic run_access(input logic rd, input logic wr, input mem_pkg::mem_type_t t,
                              input mem_pkg::addr_t a, input mem_pkg::word_t d);
        mem_read  = rd;
        mem_write = wr;
        mem_type  = t;
        addr      = a;
        wdata     = d;
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic store_op(input mem_pkg::mem_type_t t, input mem_pkg::addr_t a,
                            input mem_pkg::word_t d);
        run_access(1'b0, 1'b1, t, a, d);
    endtask

    task automatic load_op(input mem_pkg::mem_type_t t, input mem_pkg::addr_t a);
        run_access(1'b1, 1'b0, t, a, '0);
    endtask

    task automatic word_store_load();
        mem_pkg::addr_t spots [6];
        int             i;
        spots = '{32'h0000_0000, 32'h0000_0004, 32'h0000_0400,
                  32'h0000_1ffc, 32'h0000_8000, 32'h0000_fffc};
        for (i = 0; i < 6; i++) begin
            store_op(mem_pkg::MEM_WORD, spots[i], 32'hc0de_0000 ^ (spots[i] * 32'd7));
        end
        for (i = 0; i < 6; i++) begin
            load_op(mem_pkg::MEM_WORD, spots[i]);
        end
    endtask

    task automatic lane_merge();
        store_op(mem_pkg::MEM_WORD, 32'h0000_0100, 32'h1122_3344);
        store_op(mem_pkg::MEM_BYTE, 32'h0000_0101, 32'hffff_ffaa);
        store_op(mem_pkg::MEM_HALF, 32'h0000_0102, 32'h0000_beef);
        load_op(mem_pkg::MEM_WORD, 32'h0000_0100);
        store_op(mem_pkg::MEM_BYTE, 32'h0000_0103, 32'h0000_005a);
        store_op(mem_pkg::MEM_HALF, 32'h0000_0100, 32'h1234_7788);
        load_op(mem_pkg::MEM_WORD, 32'h0000_0100);
    endtask

    task automatic extension_sweep(input mem_pkg::word_t pattern);
        int off;
        store_op(mem_pkg::MEM_WORD, EXT_ADDR, pattern);
        for (off = 0; off < 4; off++) begin
            load_op(mem_pkg::MEM_BYTE, EXT_ADDR + 32'(off));
            load_op(mem_pkg::MEM_UBYTE, EXT_ADDR + 32'(off));
            if (off % 2 == 0) begin
                load_op(mem_pkg::MEM_HALF, EXT_ADDR + 32'(off));
                load_op(mem_pkg::MEM_UHALF, EXT_ADDR + 32'(off));
            end
        end
    endtask

    task automatic io_directed();
        store_op(mem_pkg::MEM_WORD, IO_BASE + 32'h4, 32'h0123_4567);
        store_op(mem_pkg::MEM_BYTE, IO_BASE + 32'h6, 32'hffff_ffa5); // Lane 2 only
        load_op(mem_pkg::MEM_WORD, IO_BASE + 32'h4);
        store_op(mem_pkg::MEM_WORD, IO_BASE + 32'h8, 32'h8765_4321);
        store_op(mem_pkg::MEM_HALF, IO_BASE + 32'ha, 32'h1234_cafe);
        load_op(mem_pkg::MEM_WORD, IO_BASE + 32'h8);
        load_op(mem_pkg::MEM_HALF, IO_BASE + 32'ha);
        load_op(mem_pkg::MEM_UBYTE, IO_BASE + 32'hb);
        store_op(mem_pkg::MEM_WORD, IO_BASE, 32'hdead_beef); // gpio
        store_op(mem_pkg::MEM_WORD, IO_BASE + 32'hc, 32'h0f0f_f0f0);
        store_op(mem_pkg::MEM_BYTE, IO_BASE + 32'hd, 32'h0000_003c);
        load_op(mem_pkg::MEM_WORD, IO_BASE + 32'hc);
        load_op(mem_pkg::MEM_WORD, IO_BASE + 32'h10);
        load_op(mem_pkg::MEM_WORD, IO_BASE + 32'h1c);
        store_op(mem_pkg::MEM_WORD, IO_BASE + 32'h1c, 32'h5555_aaaa);
        load_op(mem_pkg::MEM_WORD, IO_BASE + 32'h1c);
        load_op(mem_pkg::MEM_WORD, IO_BASE + 32'h10);
    endtask

    function automatic mem_pkg::mem_type_t pick_type(input logic for_store);
        int unsigned r;
        r = for_store ? $urandom % 3 : $urandom % 5;
        case (r)
            0:       return mem_pkg::MEM_BYTE;
            1:       return mem_pkg::MEM_HALF;
            2:       return mem_pkg::MEM_WORD;
            3:       return mem_pkg::MEM_UBYTE;
            default: return mem_pkg::MEM_UHALF;
        endcase
    endfunction

    task automatic random_mix(input int n);
        mem_pkg::mem_type_t t;
        mem_pkg::addr_t     a;
        logic [1:0]         off;
        logic               wr;
        int                 k;
        for (k = 0; k < n; k++) begin
            wr  = 1'($urandom % 2);
            t   = pick_type(wr);
            off = 2'($urandom % 4);
            if (t == mem_pkg::MEM_WORD) begin
                off = 2'b00;
            end else if (t == mem_pkg::MEM_HALF || t == mem_pkg::MEM_UHALF) begin
                off[0] = 1'b0; // Halfwords stay aligned
            end
            if ($urandom % 4 == 0) begin
                a = IO_BASE + (($urandom % 8) << 2) + {30'h0, off};
            end else begin
                a = REGION_BASE + (($urandom % N_REGION) << 2) + {30'h0, off};
            end
            run_access(~wr, wr, t, a, $urandom);
        end
    endtask

    task automatic print_counts();
        $display("Loads checked: %0d, data errors: %0d, protocol errors: %0d",
                 loads_checked, data_errors, proto_errors);
    endtask

    initial begin
        int i;
        rst_i     = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        mem_type  = mem_pkg::MEM_WORD;
        addr      = '0;
        wdata     = '0;
        void'($urandom(RAND_SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_i = 1'b0;
        repeat (2) @(posedge clk);
        #2;

        word_store_load();
        lane_merge();
        extension_sweep(32'h80ff_7f01);
        extension_sweep(32'h7f80_01fe);
        io_directed();
        for (i = 0; i < N_REGION; i++) begin
            store_op(mem_pkg::MEM_WORD, REGION_BASE + 32'(i * 4), $urandom);
        end
        random_mix(N_RANDOM);

        repeat (3) @(posedge clk); // Last load drains
        print_counts();
        if (data_errors == 0 && proto_errors == 0 && loads_checked > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: stimulus still running after %0d cycles", MAX_CYCLES);
        print_counts();
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* test/mem_checker.sv */
`timescale 1ns/100ps

module mem_checker (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               mem_read_i,
    input  logic               mem_write_i,
    input  mem_pkg::mem_type_t mem_type_i,
    input  mem_pkg::addr_t     addr_i,
    input  mem_pkg::word_t     wdata_i,
    input  logic               stall_i,
    input  logic               load_valid_i,
    input  mem_pkg::word_t     load_data_i,
    input  mem_pkg::word_t     gpio_i,
    output int                 loads_checked_o,
    output int                 data_errors_o,
    output int                 proto_errors_o
);

    mem_pkg::byte_t ram_model [mem_pkg::addr_t]; // Byte address to stored byte
    mem_pkg::word_t io_model [4];                // gpio, scratch0..2
    mem_pkg::word_t io_writes;
    mem_pkg::word_t exp_q [$];
    mem_pkg::addr_t exp_addr_q [$];
    logic           rst_q = 1'b0;
    logic           stall_seen = 1'b0;
    int             loads_checked = 0;
    int             data_errors = 0;
    int             proto_errors = 0;

    assign loads_checked_o = loads_checked;
    assign data_errors_o   = data_errors;
    assign proto_errors_o  = proto_errors;

    function automatic logic in_io_window(mem_pkg::addr_t a);
        return a[31:12] == bus_pkg::io_base_c;
    endfunction

    function automatic int access_bytes(mem_pkg::mem_type_t t);
        case (t)
            mem_pkg::MEM_WORD:                    return 4;
            mem_pkg::MEM_HALF, mem_pkg::MEM_UHALF: return 2;
            default:                              return 1;
        endcase
    endfunction

    // Load result from the stored word with little endian lanes
    function automatic mem_pkg::word_t expected_load(mem_pkg::mem_type_t t, logic [1:0] off,
                                                     mem_pkg::word_t w);
        mem_pkg::word_t sh;
        sh = w >> (8 * off);
        case (t)
            mem_pkg::MEM_BYTE:  return {{24{sh[7]}}, sh[7:0]};
            mem_pkg::MEM_UBYTE: return {24'h0, sh[7:0]};
            mem_pkg::MEM_HALF:  return {{16{sh[15]}}, sh[15:0]};
            mem_pkg::MEM_UHALF: return {16'h0, sh[15:0]};
            default:            return w;
        endcase
    endfunction

    function automatic mem_pkg::word_t ram_word(mem_pkg::addr_t a);
        mem_pkg::word_t w;
        mem_pkg::addr_t key;
        int             i;
        w = '0;
        for (i = 0; i < 4; i++) begin
            key = {a[31:2], 2'b00} + 32'(i);
            if (ram_model.exists(key)) begin
                w[8*i +: 8] = ram_model[key];
            end
        end
        return w;
    endfunction

    function automatic mem_pkg::word_t io_word(mem_pkg::addr_t a);
        if (a[11:2] == bus_pkg::io_reg_count_c) begin
            return io_writes;
        end
        if (a[11:2] <= bus_pkg::io_reg_scratch2_c) begin
            return io_model[a[3:2]];
        end
        return '0; // Unmapped offsets
    endfunction

    task automatic model_store(mem_pkg::mem_type_t t, mem_pkg::addr_t a, mem_pkg::word_t d);
        int             n;
        int             k;
        mem_pkg::addr_t start;
        n     = access_bytes(t);
        start = a & ~(32'(n) - 32'd1);
        for (k = 0; k < n; k++) begin
            if (!in_io_window(a)) begin
                ram_model[start + 32'(k)] = d[8*k +: 8];
            end else if (a[11:2] <= bus_pkg::io_reg_scratch2_c) begin
                io_model[a[3:2]][8*(int'(start[1:0]) + k) +: 8] = d[8*k +: 8];
            end
        end
        if (in_io_window(a)) begin
            io_writes++; // Writes to unmapped offsets count too
        end
    endtask

    // Ports are sampled mid-cycle
    always @(negedge clk) begin
        mem_pkg::word_t exp_val;
        mem_pkg::addr_t exp_addr;
        mem_pkg::word_t raw;
        logic           accepted;
        if (rst_i !== 1'b0 || rst_q) begin
            if (rst_q && (stall_i !== 1'b0 || load_valid_i !== 1'b0 || gpio_i !== '0)) begin
                $display("Outputs not quiet at reset at %0d ns: stall %b valid %b gpio %h",
                         $time, stall_i, load_valid_i, gpio_i);
                proto_errors++;
            end
            io_model   = '{default: '0};
            io_writes  = '0;
            stall_seen = 1'b0;
            exp_q.delete();
            exp_addr_q.delete();
        end else begin
            if (load_valid_i) begin
                if (exp_q.size() == 0) begin
                    $display("load_valid_o at %0d ns with no load outstanding", $time);
                    proto_errors++;
                end else begin
                    exp_val  = exp_q.pop_front();
                    exp_addr = exp_addr_q.pop_front();
                    loads_checked++;
                    if (load_data_i !== exp_val) begin
                        $display("Error at %0d ns: load from %h expected %h got %h",
                                 $time, exp_addr, exp_val, load_data_i);
                        data_errors++;
                    end
                end
            end else if (exp_q.size() != 0) begin
                $display("No load_valid_o at %0d ns one cycle after the load from %h",
                         $time, exp_addr_q[0]);
                proto_errors++;
                exp_q.delete();
                exp_addr_q.delete();
            end

            if ((mem_read_i || mem_write_i) && in_io_window(addr_i) && stall_i) begin
                stall_seen = 1'b1;
            end
            accepted = (mem_read_i || mem_write_i) && !stall_i; // Taken at the next edge
            if (accepted && in_io_window(addr_i)) begin
                if (!stall_seen) begin
                    $display("IO access to %h at %0d ns went through without stall_o",
                             addr_i, $time);
                    proto_errors++;
                end
                stall_seen = 1'b0;
            end
            if (accepted && mem_write_i) begin
                model_store(mem_type_i, addr_i, wdata_i);
            end
            if (accepted && mem_read_i) begin
                raw = in_io_window(addr_i) ? io_word(addr_i) : ram_word(addr_i);
                exp_q.push_back(expected_load(mem_type_i, addr_i[1:0], raw));
                exp_addr_q.push_back(addr_i);
            end

            // gpio may run ahead of the model while an IO write is stalled
            if (!stall_i && gpio_i !== io_model[0]) begin
                $display("Error at %0d ns: gpio_o expected %h got %h",
                         $time, io_model[0], gpio_i);
                data_errors++;
            end
        end
        rst_q = (rst_i === 1'b1);
    end

endmodule

/* rtl/mem_subsys_top.sv */
`timescale 1ns/100ps

module mem_subsys_top #(
    parameter int DEPTH_WORDS = 16384,
    parameter int IO_WAIT     = 2
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               mem_read_i,
    input  logic               mem_write_i,
    input  mem_pkg::mem_type_t mem_type_i,
    input  mem_pkg::addr_t     addr_i,
    input  mem_pkg::word_t     wdata_i,
    output logic               stall_o,
    output logic               load_valid_o,
    output mem_pkg::word_t     load_data_o,
    output mem_pkg::word_t     gpio_o
);

    localparam int AW = $clog2(DEPTH_WORDS);

    logic [AW-1:0]        bank_addr;
    logic [3:0]           bank_re;
    logic [3:0]           bank_we;
    mem_pkg::byte_t [3:0] bank_wdata;
    mem_pkg::byte_t [3:0] bank_rdata;
    logic                 io_req;
    logic                 io_we;
    logic                 io_ack;
    mem_pkg::addr_t       io_addr;
    mem_pkg::word_t       io_wdata;
    mem_pkg::word_t       io_rdata;
    bus_pkg::strobe_t     io_strb;

    mem_stage #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) mem_stage_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .mem_read_i   (mem_read_i),
        .mem_write_i  (mem_write_i),
        .mem_type_i   (mem_type_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .bank_addr_o  (bank_addr),
        .bank_re_o    (bank_re),
        .bank_we_o    (bank_we),
        .bank_wdata_o (bank_wdata),
        .bank_rdata_i (bank_rdata),
        .io_req_o     (io_req),
        .io_we_o      (io_we),
        .io_addr_o    (io_addr),
        .io_wdata_o   (io_wdata),
        .io_strb_o    (io_strb),
        .io_ack_i     (io_ack),
        .io_rdata_i   (io_rdata),
        .stall_o      (stall_o),
        .load_valid_o (load_valid_o),
        .load_data_o  (load_data_o)
    );

    // Bank n holds byte lane n
    for (genvar i = 0; i < 4; i++) begin : g_bank
        dmem_bank #(
            .DEPTH_WORDS (DEPTH_WORDS)
        ) dmem_bank_i (
            .clk     (clk),
            .addr_i  (bank_addr),
            .re_i    (bank_re[i]),
            .we_i    (bank_we[i]),
            .wdata_i (bank_wdata[i]),
            .rdata_o (bank_rdata[i])
        );
    end

    io_regs #(
        .IO_WAIT (IO_WAIT)
    ) io_regs_i (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (io_req),
        .we_i    (io_we),
        .addr_i  (io_addr),
        .wdata_i (io_wdata),
        .strb_i  (io_strb),
        .ack_o   (io_ack),
        .rdata_o (io_rdata),
        .gpio_o  (gpio_o)
    );

endmodule

/* rtl/io_regs.sv */
`timescale 1ns/100ps

module io_regs #(
    parameter int IO_WAIT = 2
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             req_i,
    input  logic             we_i,
    input  mem_pkg::addr_t   addr_i,
    input  mem_pkg::word_t   wdata_i,
    input  bus_pkg::strobe_t strb_i,
    output logic             ack_o,
    output mem_pkg::word_t   rdata_o,
    output mem_pkg::word_t   gpio_o
);

    localparam int CW = $clog2(IO_WAIT + 2);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_ACK
    } state_t;

    state_t         state_q;
    logic [CW-1:0]  wait_q;
    logic [9:0]     offset;
    logic           do_access;
    mem_pkg::word_t rd_val;
    mem_pkg::word_t gpio_q;
    mem_pkg::word_t scratch_q [3];
    mem_pkg::word_t wr_count_q;

    // Write only the strobed lanes
    function automatic mem_pkg::word_t merge_lanes(mem_pkg::word_t cur,
                                                   mem_pkg::word_t nxt,
                                                   bus_pkg::strobe_t strb);
        mem_pkg::word_t res;
        int             i;
        res = cur;
        for (i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = nxt[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign offset    = addr_i[11:2];
    assign do_access = (state_q == ST_WAIT) && (wait_q == '0);
    assign gpio_o    = gpio_q;

    always_comb begin
        case (offset)
            bus_pkg::io_reg_gpio_c:     rd_val = gpio_q;
            bus_pkg::io_reg_scratch0_c: rd_val = scratch_q[0];
            bus_pkg::io_reg_scratch1_c: rd_val = scratch_q[1];
            bus_pkg::io_reg_scratch2_c: rd_val = scratch_q[2];
            bus_pkg::io_reg_count_c:    rd_val = wr_count_q;
            default:                    rd_val = '0; // Unmapped
        endcase
    end

    // Wait, access, then hold ack until req falls
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            wait_q  <= '0;
            ack_o   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_i) begin
                        wait_q  <= CW'(IO_WAIT);
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (do_access) begin
                        ack_o   <= 1'b1;
                        state_q <= ST_ACK;
                    end else begin
                        wait_q <= wait_q - 1'b1;
                    end
                end
                ST_ACK: begin
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            gpio_q     <= '0;
            scratch_q  <= '{default: '0};
            wr_count_q <= '0;
        end else if (do_access && we_i) begin
            wr_count_q <= wr_count_q + 1'b1; // Every IO write counts
            case (offset)
                bus_pkg::io_reg_gpio_c: begin
                    gpio_q <= merge_lanes(gpio_q, wdata_i, strb_i);
                end
                bus_pkg::io_reg_scratch0_c: begin
                    scratch_q[0] <= merge_lanes(scratch_q[0], wdata_i, strb_i);
                end
                bus_pkg::io_reg_scratch1_c: begin
                    scratch_q[1] <= merge_lanes(scratch_q[1], wdata_i, strb_i);
                end
                bus_pkg::io_reg_scratch2_c: begin
                    scratch_q[2] <= merge_lanes(scratch_q[2], wdata_i, strb_i);
                end
                default: begin
                end
            endcase
        end
    end

    // Read data, held through the ack phase
    always_ff @(posedge clk) begin
        if (do_access) begin
            rdata_o <= rd_val;
        end
    end

endmodule

/* rtl/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage #(
    parameter int DEPTH_WORDS = 16384
) (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           mem_read_i,
    input  logic                           mem_write_i,
    input  mem_pkg::mem_type_t             mem_type_i,
    input  mem_pkg::addr_t                 addr_i,
    input  mem_pkg::word_t                 wdata_i,
    output logic [$clog2(DEPTH_WORDS)-1:0] bank_addr_o,
    output logic [3:0]                     bank_re_o,
    output logic [3:0]                     bank_we_o,
    output mem_pkg::byte_t [3:0]           bank_wdata_o,
    input  mem_pkg::byte_t [3:0]           bank_rdata_i,
    output logic                           io_req_o,
    output logic                           io_we_o,
    output mem_pkg::addr_t                 io_addr_o,
    output mem_pkg::word_t                 io_wdata_o,
    output bus_pkg::strobe_t               io_strb_o,
    input  logic                           io_ack_i,
    input  mem_pkg::word_t                 io_rdata_i,
    output logic                           stall_o,
    output logic                           load_valid_o,
    output mem_pkg::word_t                 load_data_o
);

    localparam int AW = $clog2(DEPTH_WORDS);

    typedef enum logic [1:0] {
        IO_IDLE,
        IO_REQ,
        IO_RELEASE,
        IO_DONE
    } io_state_t;

    io_state_t          io_state_q;
    io_state_t          io_state_d;
    logic               is_io;
    logic               io_access;
    logic               store_ok;
    logic [3:0]         lanes;
    mem_pkg::word_t     lane_data;
    logic               accept_load;
    logic               src_io_q;
    mem_pkg::mem_type_t type_q;
    logic [1:0]         offset_q;
    mem_pkg::word_t     io_rdata_q;
    mem_pkg::word_t     raw_word;

    // Decode and lane steering, shared by RAM and IO
    assign is_io     = (addr_i[31:12] == bus_pkg::io_base_c);
    assign io_access = is_io && (mem_read_i || mem_write_i);
    assign store_ok  = mem_write_i && mem_pkg::is_store_type(mem_type_i);
    assign lanes     = mem_pkg::lane_mask(mem_type_i, addr_i[1:0]);
    assign lane_data = mem_pkg::store_shift(wdata_i, mem_type_i, addr_i[1:0]);

    assign bank_addr_o  = addr_i[AW+1:2]; // Word index
    assign bank_re_o    = lanes & {4{mem_read_i && !is_io}};
    assign bank_we_o    = lanes & {4{store_ok && !is_io}};
    assign bank_wdata_o = lane_data;

    // Source holds the access steady while stalled
    assign io_req_o   = (io_state_q == IO_REQ);
    assign io_we_o    = store_ok;
    assign io_addr_o  = addr_i;
    assign io_wdata_o = lane_data;
    assign io_strb_o  = lanes;

    // Four-phase sequencer
    always_comb begin
        io_state_d = io_state_q;
        case (io_state_q)
            IO_IDLE: begin
                if (io_access) begin
                    io_state_d = IO_REQ;
                end
            end
            IO_REQ: begin
                if (io_ack_i) begin
                    io_state_d = IO_RELEASE; // Data sampled this edge
                end
            end
            IO_RELEASE: begin
                if (!io_ack_i) begin
                    io_state_d = IO_DONE;
                end
            end
            default: io_state_d = IO_IDLE; // DONE lasts one cycle
        endcase
    end

    assign stall_o = (io_state_q == IO_REQ) || (io_state_q == IO_RELEASE) ||
                     ((io_state_q == IO_IDLE) && io_access);

    // RAM loads go straight through, IO loads land in DONE
    assign accept_load = mem_read_i && !stall_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            io_state_q   <= IO_IDLE;
            load_valid_o <= 1'b0;
        end else begin
            io_state_q   <= io_state_d;
            load_valid_o <= accept_load;
        end
    end

    // Context of the load in flight
    always_ff @(posedge clk) begin
        if (accept_load) begin
            type_q   <= mem_type_i;
            offset_q <= addr_i[1:0];
            src_io_q <= is_io;
        end
        if (io_req_o && io_ack_i) begin
            io_rdata_q <= io_rdata_i;
        end
    end

    assign raw_word = src_io_q ? io_rdata_q : bank_rdata_i;

    load_align load_align_i (
        .raw_i    (raw_word),
        .type_i   (type_q),
        .offset_i (offset_q),
        .data_o   (load_data_o)
    );

endmodule

/* rtl/load_align.sv */
`timescale 1ns/100ps

module load_align (
    input  mem_pkg::word_t     raw_i,
    input  mem_pkg::mem_type_t type_i,
    input  logic [1:0]         offset_i,
    output mem_pkg::word_t     data_o
);

    mem_pkg::byte_t sel_byte;
    logic [15:0]    sel_half;

    // Pick out the addressed lane(s)
    always_comb begin
        case (offset_i)
            2'd0:    sel_byte = raw_i[7:0];
            2'd1:    sel_byte = raw_i[15:8];
            2'd2:    sel_byte = raw_i[23:16];
            default: sel_byte = raw_i[31:24];
        endcase
        sel_half = offset_i[1] ? raw_i[31:16] : raw_i[15:0]; // Bit 0 ignored
    end

    always_comb begin
        case (type_i)
            mem_pkg::MEM_BYTE:  data_o = {{24{sel_byte[7]}}, sel_byte};
            mem_pkg::MEM_UBYTE: data_o = {24'h0, sel_byte};
            mem_pkg::MEM_HALF:  data_o = {{16{sel_half[15]}}, sel_half};
            mem_pkg::MEM_UHALF: data_o = {16'h0, sel_half};
            default:            data_o = raw_i; // Full word
        endcase
    end

endmodule

/* rtl/dmem_bank.sv */
`timescale 1ns/100ps

module dmem_bank #(
    parameter int DEPTH_WORDS = 16384
) (
    input  logic                           clk,
    input  logic [$clog2(DEPTH_WORDS)-1:0] addr_i,
    input  logic                           re_i,
    input  logic                           we_i,
    input  mem_pkg::byte_t                 wdata_i,
    output mem_pkg::byte_t                 rdata_o
);

    mem_pkg::byte_t mem [DEPTH_WORDS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        if (re_i) begin
            rdata_o <= mem[addr_i]; // Last read stays put while re is low
        end
    end

endmodule

/* rtl/bus_pkg.sv */
package bus_pkg;

    // Tag for address bits 31:12 of the peripheral window
    localparam logic [19:0] io_base_c = 20'h40000;

    // Register word offsets, address bits 11:2
    localparam logic [9:0] io_reg_gpio_c     = 10'd0;
    localparam logic [9:0] io_reg_scratch0_c = 10'd1;
    localparam logic [9:0] io_reg_scratch1_c = 10'd2;
    localparam logic [9:0] io_reg_scratch2_c = 10'd3;
    localparam logic [9:0] io_reg_count_c    = 10'd4; // Read only

    // One bit per byte lane, bit 0 is data[7:0]
    typedef logic [3:0] strobe_t;

endpackage

/* rtl/mem_pkg.sv */
package mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // Same codes as the RV32 load/store funct3 field
    typedef enum logic [2:0] {
        MEM_BYTE  = 3'b000,
        MEM_HALF  = 3'b001,
        MEM_WORD  = 3'b010,
        MEM_UBYTE = 3'b100,
        MEM_UHALF = 3'b101
    } mem_type_t;

    // Byte lanes touched by an access of type t at offset off
    function automatic logic [3:0] lane_mask(mem_type_t t, logic [1:0] off);
        logic [3:0] m;
        case (t)
            MEM_BYTE, MEM_UBYTE: m = 4'b0001 << off;
            MEM_HALF, MEM_UHALF: m = off[1] ? 4'b1100 : 4'b0011;
            MEM_WORD:            m = 4'b1111;
            default:             m = 4'b0000;
        endcase
        return m;
    endfunction

    // Moves store data up onto its lanes
    function automatic word_t store_shift(word_t d, mem_type_t t, logic [1:0] off);
        word_t s;
        case (t)
            MEM_BYTE: s = {24'h0, d[7:0]} << {off, 3'b000};
            MEM_HALF: s = {16'h0, d[15:0]} << {off[1], 4'h0};
            default:  s = d;
        endcase
        return s;
    endfunction

    // Unsigned types only ever read
    function automatic logic is_store_type(mem_type_t t);
        return (t == MEM_BYTE) || (t == MEM_HALF) || (t == MEM_WORD);
    endfunction

endpackage
